// File: all.f
rtl/trigger_pkg.sv
rtl/event_fifo.sv
rtl/ttc_trigger_receiver.sv
rtl/channel_acq_controller.sv
rtl/trigger_processor.sv
rtl/trigger_top.sv
dv/tb_clock_gen.sv
dv/trigger_top_tb.sv

// File: Makefile
# Verilator build and run of the trigger path testbench

VERILATOR ?= verilator
TOP       ?= trigger_top_tb
FILELIST  ?= all.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
FAIL_MSG  ?= Done: errors found

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "simulation failed"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: dv/trigger_top_tb.sv
// Trigger path testbench

module trigger_top_tb;
    import trigger_pkg::*;

    localparam int NUM_ROWS   = 8;
    localparam int LIMIT      = 400;    // cycles allowed for any one wait
    localparam int RST_CYCLES = 10;

    // wait conditions
    localparam int W_RESET     = 0;
    localparam int W_ENABLE    = 1;
    localparam int W_CHAN_TRIG = 2;
    localparam int W_CAC_IDLE  = 3;
    localparam int W_READOUT   = 4;
    localparam int W_TP_IDLE   = 5;

    typedef struct packed {
        trig_type_t typ;
        chan_mask_t mask;
        delay_t     delay;
        int         holdoff;    // cycles readout_ready stays low after the store
        bit         extra;      // second trigger while busy
    } row_t;

    logic       ttc_clk;
    logic       rst_n;

    // DUT inputs
    logic       ttc_trigger;
    trig_type_t trig_type;
    logic       rst_trigger_num;
    logic       rst_trigger_timestamp;
    chan_mask_t chan_en;
    delay_t     trig_delay;
    chan_mask_t chan_dones;
    logic       readout_ready;
    logic       readout_done;

    // DUT outputs
    chan_mask_t chan_enable;
    chan_mask_t chan_trig;
    logic       initiate_readout;
    logic       send_empty_event;
    trig_num_t  ttc_trig_num;
    trig_type_t ttc_trig_type;
    timestamp_t ttc_trig_timestamp;
    trig_num_t  trig_num;
    timestamp_t trig_timestamp;
    logic       trig_fifo_full;
    logic       acq_fifo_full;
    logic       error_trig_rate;
    logic       error_trig_num;
    logic       error_trig_type;
    ttr_state_t ttr_state;
    cac_state_t cac_state;
    tp_state_t  tp_state;

    row_t       rows [NUM_ROWS];
    integer     seed;
    int         checks;
    int         mismatches;
    int         failures;
    int         cycle;
    logic       run_over;       // last row done or a wait timed out

    // monitor record
    int         chan_trig_cnt;
    int         readout_cnt;
    int         empty_cnt;
    int         last_trig_cycle;
    chan_mask_t last_trig_mask;
    trig_num_t  rd_num;
    trig_type_t rd_type;
    timestamp_t rd_ts;

    // channel and readout models
    chan_mask_t ch_mask;
    logic       ch_active;
    int         done_wait [NUM_CHAN];
    int         rd_wait;
    logic       drop_dones;

    // expected state
    int         exp_num;        // accepted since the last number reset
    logic       exp_rate_err;
    timestamp_t prev_ts;
    int         trig_before;
    int         rd_before;

    tb_clock_gen #(.PERIOD(40), .RST_CYCLES(RST_CYCLES)) clock_gen (
        .clk(ttc_clk),
        .rst_n(rst_n)
    );

    trigger_top DUT (.*);

    // ----------------------------------------
    // checks and reporting
    // ----------------------------------------
    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        checks++;
        if (got !== exp) begin
            mismatches++;
            $display("Mismatch %s: got 0x%0h, expected 0x%0h (cycle %0d)",
                     name, got, exp, cycle);
        end
    endtask

    task automatic report_failure(input string msg);
        failures++;
        $display("Failure at cycle %0d: %s", cycle, msg);
    endtask

    task automatic finish_run;
        $display("checks %0d, mismatches %0d, other failures %0d",
                 checks, mismatches, failures);
        if (mismatches == 0 && failures == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    endtask

    function automatic logic cond_met(input int what);
        case (what)
            W_RESET:     return rst_n;
            W_ENABLE:    return chan_enable != '0;
            W_CHAN_TRIG: return chan_trig_cnt > trig_before;
            W_CAC_IDLE:  return cac_state == CAC_IDLE;
            W_READOUT:   return readout_cnt > rd_before;
            W_TP_IDLE:   return tp_state == TP_IDLE;
            default:     return 1'b1;
        endcase
    endfunction

    // ----------------------------------------
    // stimulus helpers
    // ----------------------------------------
    task automatic next_cycle;
        @(posedge ttc_clk);
        #2;     // drive point, outputs of this edge are settled
    endtask

    task automatic wait_for(input int what, input string what_msg);
        int n;
        n = 0;
        while (cond_met(what) !== 1'b1 && n < LIMIT) begin
            next_cycle();
            n++;
        end
        if (cond_met(what) !== 1'b1) begin
            report_failure({"timed out waiting for ", what_msg});
            run_over = 1'b1;
            forever next_cycle();       // closing process ends the run
        end
    endtask

    task automatic send_trigger(input trig_type_t typ);
        ttc_trigger = 1'b1;
        trig_type   = typ;
        next_cycle();
        ttc_trigger = 1'b0;
    endtask

    task automatic pulse_num_reset;
        rst_trigger_num = 1'b1;
        next_cycle();
        rst_trigger_num = 1'b0;
        exp_num = 0;
        check_value("trig_num", trig_num, 0);
    endtask

    // one table row, trigger through readout_done
    task automatic run_row(input row_t r);
        int         start;
        timestamp_t exp_ts;     // counter is zero in the cycle reset drops
        chan_en       = r.mask;
        trig_delay    = r.delay;
        readout_ready = (r.holdoff == 0);
        trig_before   = chan_trig_cnt;
        rd_before     = readout_cnt;
        next_cycle();
        start  = cycle;
        exp_ts = timestamp_t'(start - RST_CYCLES);
        send_trigger(r.typ);
        exp_num++;
        check_value("trig_num", trig_num, exp_num);
        check_value("trig_timestamp", trig_timestamp, exp_ts);

        if (r.extra) begin
            wait_for(W_ENABLE, "chan_enable");
            check_value("chan_enable", chan_enable, r.mask);
            send_trigger(~r.typ);       // must be dropped
            exp_rate_err = 1'b1;
            check_value("error_trig_rate", error_trig_rate, 1);
            check_value("trig_num", trig_num, exp_num);
            check_value("trig_timestamp", trig_timestamp, exp_ts);
        end

        wait_for(W_CHAN_TRIG, "chan_trig");
        check_value("chan_trig", last_trig_mask, r.mask);
        check_value("chan_trig latency", last_trig_cycle - start, r.delay + 3);

        if (r.holdoff > 0) begin
            wait_for(W_CAC_IDLE, "the acquisition event store");
            repeat (r.holdoff) next_cycle();
            check_value("initiate_readout count", readout_cnt, rd_before);
            check_value("trig_fifo_full", trig_fifo_full, 0);  // one record held
            check_value("acq_fifo_full", acq_fifo_full, 0);
            readout_ready = 1'b1;
        end

        wait_for(W_READOUT, "initiate_readout");
        check_value("ttc_trig_num", rd_num, exp_num);
        check_value("ttc_trig_type", rd_type, r.typ);
        check_value("ttc_trig_timestamp", rd_ts, exp_ts);
        if (rd_ts <= prev_ts) begin
            report_failure("ttc_trig_timestamp did not increase");
        end
        prev_ts = rd_ts;
        wait_for(W_TP_IDLE, "the processor to finish the readout");

        next_cycle();
        check_value("chan_trig pulses", chan_trig_cnt, trig_before + 1);
        check_value("initiate_readout pulses", readout_cnt, rd_before + 1);
        check_value("send_empty_event pulses", empty_cnt, 0);
        check_value("error_trig_rate", error_trig_rate, exp_rate_err);
        check_value("error_trig_num", error_trig_num, 0);
        check_value("error_trig_type", error_trig_type, 0);
    endtask

    // ----------------------------------------
    // monitor, channel model, readout model
    // ----------------------------------------
    always @(posedge ttc_clk) begin
        #1;                             // sample point
        cycle++;
        drop_dones = 1'b0;
        if (rst_n) begin
            if (ch_active && (chan_dones & ch_mask) != ch_mask) begin
                check_value("chan_enable", chan_enable, chan_en);
            end
            if (chan_trig != '0) begin
                chan_trig_cnt++;
                last_trig_cycle = cycle;
                last_trig_mask  = chan_trig;
                ch_mask         = chan_trig;
                ch_active       = 1'b1;
                for (int i = 0; i < NUM_CHAN; i++) begin
                    done_wait[i] = 1 + ($random(seed) & 7);
                end
            end
            if (initiate_readout) begin
                readout_cnt++;
                rd_num  = ttc_trig_num;
                rd_type = ttc_trig_type;
                rd_ts   = ttc_trig_timestamp;
                rd_wait = 2 + ($random(seed) & 7);  // at least one cycle in TP_READOUT
                if (!readout_ready) begin
                    report_failure("initiate_readout while readout_ready was low");
                end
            end
            if (send_empty_event) begin
                empty_cnt++;
            end
            drop_dones = initiate_readout || send_empty_event;    // heads popped
        end
        #1;                             // drive point
        readout_done = 1'b0;
        if (rd_wait > 0) begin
            rd_wait--;
            if (rd_wait == 0) begin
                readout_done = 1'b1;
            end
        end
        if (drop_dones) begin
            chan_dones = '0;
            ch_active  = 1'b0;
        end else if (ch_active) begin
            for (int i = 0; i < NUM_CHAN; i++) begin
                if (ch_mask[i] && done_wait[i] > 0) begin
                    done_wait[i]--;
                    if (done_wait[i] == 0) begin
                        chan_dones[i] = 1'b1;
                    end
                end
            end
        end
    end

    // ----------------------------------------
    // main sequence
    // ----------------------------------------
    initial begin
        seed                  = 32'hffcc2183;
        ttc_trigger           = 1'b0;
        trig_type             = '0;
        rst_trigger_num       = 1'b0;
        rst_trigger_timestamp = 1'b0;
        chan_en               = '0;
        trig_delay            = '0;
        chan_dones            = '0;
        readout_ready         = 1'b1;
        readout_done          = 1'b0;
        checks        = 0;
        mismatches    = 0;
        failures      = 0;
        cycle         = 0;
        run_over      = 1'b0;
        chan_trig_cnt = 0;
        readout_cnt   = 0;
        empty_cnt     = 0;
        ch_active     = 1'b0;
        rd_wait       = 0;
        exp_num       = 0;
        exp_rate_err  = 1'b0;
        prev_ts       = '0;

        // type, mask, delay, readout hold-off, extra trigger
        rows = '{
            '{5'h01, 5'b11111, 8'd0,   0,  1'b0},
            '{5'h02, 5'b00101, 8'd3,   0,  1'b0},
            '{5'h1f, 5'b10000, 8'd10,  4,  1'b0},
            '{5'h07, 5'b01010, 8'd1,   0,  1'b1},
            '{5'h11, 5'b11001, 8'd25,  7,  1'b0},
            '{5'h00, 5'b00001, 8'd2,   0,  1'b1},
            '{5'h15, 5'b01111, 8'd255, 2,  1'b0},
            '{5'h0a, 5'b10101, 8'd5,   12, 1'b0}
        };

        wait_for(W_RESET, "reset release");
        next_cycle();
        check_value("chan_trig", chan_trig, 0);
        check_value("chan_enable", chan_enable, 0);
        check_value("initiate_readout", initiate_readout, 0);
        check_value("send_empty_event", send_empty_event, 0);
        check_value("error_trig_rate", error_trig_rate, 0);
        check_value("error_trig_num", error_trig_num, 0);
        check_value("error_trig_type", error_trig_type, 0);
        check_value("trig_num", trig_num, 0);
        check_value("trig_fifo_full", trig_fifo_full, 0);
        check_value("acq_fifo_full", acq_fifo_full, 0);
        check_value("ttr_state", ttr_state, TTR_IDLE);
        check_value("cac_state", cac_state, CAC_IDLE);
        check_value("tp_state", tp_state, TP_IDLE);

        // second pass starts over at trigger number 1
        for (int pass = 0; pass < 2; pass++) begin
            if (pass == 1) begin
                pulse_num_reset();
            end
            for (int i = 0; i < NUM_ROWS; i++) begin
                run_row(rows[i]);
            end
        end

        run_over = 1'b1;
    end

    // end of the run, after the last row or a timeout
    initial begin
        @(posedge run_over);
        finish_run();
    end

endmodule

// File: dv/tb_clock_gen.sv
// Testbench clock and reset

module tb_clock_gen #(
    parameter int PERIOD     = 40,
    parameter int RST_CYCLES = 10
) (
    output logic clk,
    output logic rst_n
);
    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    // reset drops off the edge, same as the other inputs
    initial begin
        rst_n = 1'b0;
        repeat (RST_CYCLES) @(posedge clk);
        #2 rst_n = 1'b1;
    end

endmodule

// File: rtl/trigger_top.sv
// TTC trigger path top level

module trigger_top (
    input  logic                    ttc_clk,
    input  logic                    rst_n,
    input  logic                    ttc_trigger,
    input  trigger_pkg::trig_type_t trig_type,
    input  logic                    rst_trigger_num,        // TTC channel B
    input  logic                    rst_trigger_timestamp,  // TTC channel B
    input  trigger_pkg::chan_mask_t chan_en,
    input  trigger_pkg::delay_t     trig_delay,
    input  trigger_pkg::chan_mask_t chan_dones,
    input  logic                    readout_ready,
    input  logic                    readout_done,
    output trigger_pkg::chan_mask_t chan_enable,
    output trigger_pkg::chan_mask_t chan_trig,
    output logic                    initiate_readout,
    output logic                    send_empty_event,
    output trigger_pkg::trig_num_t  ttc_trig_num,
    output trigger_pkg::trig_type_t ttc_trig_type,
    output trigger_pkg::timestamp_t ttc_trig_timestamp,
    output trigger_pkg::trig_num_t  trig_num,
    output trigger_pkg::timestamp_t trig_timestamp,
    output logic                    trig_fifo_full,
    output logic                    acq_fifo_full,
    output logic                    error_trig_rate,
    output logic                    error_trig_num,
    output logic                    error_trig_type,
    output trigger_pkg::ttr_state_t ttr_state,
    output trigger_pkg::cac_state_t cac_state,
    output trigger_pkg::tp_state_t  tp_state
);
    import trigger_pkg::*;

    // receiver to controller
    logic       acq_trigger;
    trig_num_t  acq_trig_num;
    trig_type_t acq_trig_type;
    logic       acq_ready;

    // fifo sides
    logic                  trig_wr;
    logic [TRIG_REC_W-1:0] trig_rec;
    logic [TRIG_REC_W-1:0] trig_head;
    logic                  trig_empty;
    logic                  acq_wr;
    logic [ACQ_REC_W-1:0]  acq_rec;
    logic [ACQ_REC_W-1:0]  acq_head;
    logic                  acq_empty;
    logic                  fifo_rd;     // one pop for both fifos

    ttc_trigger_receiver ttc_trigger_receiver (
        .trig_full(trig_fifo_full),
        .*
    );

    channel_acq_controller channel_acq_controller (
        .acq_full(acq_fifo_full),
        .*
    );

    trigger_processor trigger_processor (.*);

    // trigger records, {timestamp, number, type}
    event_fifo #(
        .WIDTH(TRIG_REC_W),
        .DEPTH(TRIG_FIFO_DEPTH)
    ) trig_fifo (
        .ttc_clk(ttc_clk),
        .rst_n(rst_n),
        .wr(trig_wr),
        .wdata(trig_rec),
        .full(trig_fifo_full),
        .rd(fifo_rd),
        .rdata(trig_head),
        .empty(trig_empty)
    );

    // acquisition events, {number, type}
    event_fifo #(
        .WIDTH(ACQ_REC_W),
        .DEPTH(ACQ_FIFO_DEPTH)
    ) acq_fifo (
        .ttc_clk(ttc_clk),
        .rst_n(rst_n),
        .wr(acq_wr),
        .wdata(acq_rec),
        .full(acq_fifo_full),
        .rd(fifo_rd),
        .rdata(acq_head),
        .empty(acq_empty)
    );

endmodule

// File: rtl/trigger_processor.sv
// Trigger processor

module trigger_processor (
    input  logic                               ttc_clk,
    input  logic                               rst_n,
    input  logic                               trig_empty,
    input  logic [trigger_pkg::TRIG_REC_W-1:0] trig_head,      // trigger fifo head
    input  logic                               acq_empty,
    input  logic [trigger_pkg::ACQ_REC_W-1:0]  acq_head,       // event fifo head
    input  logic                               readout_ready,  // command manager idle
    input  logic                               readout_done,   // pulse
    output logic                               fifo_rd,        // pops both heads
    output logic                               initiate_readout,
    output logic                               send_empty_event,
    output trigger_pkg::trig_num_t             ttc_trig_num,
    output trigger_pkg::trig_type_t            ttc_trig_type,
    output trigger_pkg::timestamp_t            ttc_trig_timestamp,
    output logic                               error_trig_num,  // sticky
    output logic                               error_trig_type, // sticky
    output trigger_pkg::tp_state_t             tp_state
);
    import trigger_pkg::*;

    // head fields
    timestamp_t head_ts;
    trig_num_t  head_num;
    trig_type_t head_type;
    trig_num_t  evt_num;
    trig_type_t evt_type;
    logic       num_ok;
    logic       type_ok;

    assign {head_ts, head_num, head_type} = trig_head;
    assign {evt_num, evt_type}            = acq_head;

    assign num_ok  = (head_num == evt_num);
    assign type_ok = (head_type == evt_type);

    // both heads go in one pop
    assign fifo_rd = (tp_state == TP_IDLE) && !trig_empty && !acq_empty && readout_ready;

    // ----------------------------------------
    // readout request FSM
    // ----------------------------------------
    always_ff @(posedge ttc_clk) begin
        if (!rst_n) begin
            tp_state         <= TP_IDLE;
            initiate_readout <= 1'b0;
            send_empty_event <= 1'b0;
            error_trig_num   <= 1'b0;
            error_trig_type  <= 1'b0;
        end else begin
            initiate_readout <= 1'b0;
            send_empty_event <= 1'b0;
            case (tp_state)
                TP_IDLE: begin
                    if (fifo_rd) begin
                        tp_state <= TP_CHECK;
                        if (num_ok && type_ok) begin
                            initiate_readout <= 1'b1;
                        end else begin
                            send_empty_event <= 1'b1;   // fifos out of step
                            error_trig_num   <= error_trig_num | !num_ok;
                            error_trig_type  <= error_trig_type | !type_ok;
                        end
                    end
                end
                TP_CHECK: begin
                    // outcome pulse is out this cycle
                    tp_state <= initiate_readout ? TP_READOUT : TP_IDLE;
                end
                TP_READOUT: begin
                    if (readout_done) begin
                        tp_state <= TP_IDLE;
                    end
                end
                default: tp_state <= TP_IDLE;
            endcase
        end
    end

    // readout header, valid with initiate_readout
    always_ff @(posedge ttc_clk) begin
        if (fifo_rd && num_ok && type_ok) begin
            ttc_trig_num       <= head_num;
            ttc_trig_type      <= head_type;
            ttc_trig_timestamp <= head_ts;
        end
    end

    a_one_outcome: assert property (@(posedge ttc_clk) disable iff (!rst_n)
        !(initiate_readout && send_empty_event))
        else $error("trigger_processor: readout and empty event together");

endmodule

// File: rtl/channel_acq_controller.sv
// Channel acquisition controller

module channel_acq_controller (
    input  logic                              ttc_clk,
    input  logic                              rst_n,
    input  logic                              acq_trigger,   // from the receiver
    input  trigger_pkg::trig_num_t            acq_trig_num,
    input  trigger_pkg::trig_type_t           acq_trig_type,
    input  trigger_pkg::chan_mask_t           chan_en,       // channels to trigger
    input  trigger_pkg::delay_t               trig_delay,
    input  trigger_pkg::chan_mask_t           chan_dones,    // levels from the channels
    input  logic                              acq_full,
    output logic                              acq_ready,
    output trigger_pkg::chan_mask_t           chan_enable,   // held mask
    output trigger_pkg::chan_mask_t           chan_trig,     // one-cycle pulse
    output logic                              acq_wr,
    output logic [trigger_pkg::ACQ_REC_W-1:0] acq_rec,
    output trigger_pkg::cac_state_t           cac_state
);
    import trigger_pkg::*;

    trig_num_t  num_q;
    trig_type_t type_q;
    delay_t     delay_cnt;
    logic       all_done;

    assign acq_ready = (cac_state == CAC_IDLE);
    assign all_done  = ((chan_dones & chan_enable) == chan_enable);
    assign acq_wr    = (cac_state == CAC_STORE) && !acq_full;   // waits out back-pressure
    assign acq_rec   = {num_q, type_q};

    // event fields, kept until the store
    always_ff @(posedge ttc_clk) begin
        if (acq_trigger && acq_ready) begin
            num_q  <= acq_trig_num;
            type_q <= acq_trig_type;
        end
    end

    // ----------------------------------------
    // acquisition FSM
    // ----------------------------------------
    always_ff @(posedge ttc_clk) begin
        if (!rst_n) begin
            cac_state   <= CAC_IDLE;
            chan_enable <= '0;
            chan_trig   <= '0;
            delay_cnt   <= '0;
        end else begin
            chan_trig <= '0;
            case (cac_state)
                CAC_IDLE: begin
                    if (acq_trigger) begin
                        chan_enable <= chan_en;
                        delay_cnt   <= trig_delay;
                        // nothing enabled, nothing to wait for
                        cac_state   <= (chan_en == '0) ? CAC_STORE : CAC_DELAY;
                    end
                end
                CAC_DELAY: begin
                    if (delay_cnt == '0) begin
                        chan_trig <= chan_enable;   // trig_delay+1 after the trigger
                        cac_state <= CAC_ACQ;
                    end else begin
                        delay_cnt <= delay_cnt - 1'b1;
                    end
                end
                CAC_ACQ: begin
                    if (all_done) begin
                        chan_enable <= '0;
                        cac_state   <= CAC_STORE;
                    end
                end
                CAC_STORE: begin
                    if (!acq_full) begin
                        cac_state <= CAC_IDLE;
                    end
                end
                default: cac_state <= CAC_IDLE;
            endcase
        end
    end

    // channels only see a trigger while they are enabled
    a_trig_in_mask: assert property (@(posedge ttc_clk) disable iff (!rst_n)
        (chan_trig & ~chan_enable) == '0)
        else $error("channel_acq_controller: chan_trig outside chan_enable");

    // the receiver holds back while we are busy
    a_trig_when_ready: assert property (@(posedge ttc_clk) disable iff (!rst_n)
        acq_trigger |-> acq_ready)
        else $error("channel_acq_controller: trigger while busy");

endmodule

// File: rtl/ttc_trigger_receiver.sv
// TTC trigger receiver

module ttc_trigger_receiver (
    input  logic                               ttc_clk,
    input  logic                               rst_n,
    input  logic                               ttc_trigger,     // one-cycle pulse
    input  trigger_pkg::trig_type_t            trig_type,       // sampled with the pulse
    input  logic                               rst_trigger_num, // TTC channel B
    input  logic                               rst_trigger_timestamp,
    input  logic                               acq_ready,       // controller idle
    input  logic                               trig_full,
    output logic                               acq_trigger,
    output trigger_pkg::trig_num_t             acq_trig_num,
    output trigger_pkg::trig_type_t            acq_trig_type,
    output logic                               trig_wr,
    output logic [trigger_pkg::TRIG_REC_W-1:0] trig_rec,
    output trigger_pkg::trig_num_t             trig_num,        // last accepted number
    output trigger_pkg::timestamp_t            trig_timestamp,  // of the last accepted trigger
    output logic                               error_trig_rate, // sticky
    output trigger_pkg::ttr_state_t            ttr_state
);
    import trigger_pkg::*;

    timestamp_t ts_cnt;     // free running
    trig_num_t  next_num;
    logic       accept;

    assign accept = ttc_trigger && (ttr_state == TTR_IDLE) && acq_ready && !trig_full;

    // a number reset in the same cycle makes this trigger number 1
    assign next_num = rst_trigger_num ? trig_num_t'(1) : trig_num + 1'b1;

    always_ff @(posedge ttc_clk) begin
        if (!rst_n || rst_trigger_timestamp) begin
            ts_cnt <= '0;
        end else begin
            ts_cnt <= ts_cnt + 1'b1;
        end
    end

    // ----------------------------------------
    // acceptance FSM
    // ----------------------------------------
    always_ff @(posedge ttc_clk) begin
        if (!rst_n) begin
            ttr_state       <= TTR_IDLE;
            acq_trigger     <= 1'b0;
            trig_wr         <= 1'b0;
            trig_num        <= '0;
            error_trig_rate <= 1'b0;
        end else begin
            acq_trigger <= accept;
            trig_wr     <= accept;              // fifo write goes with the trigger
            if (ttc_trigger && !accept) begin
                error_trig_rate <= 1'b1;        // too fast, dropped
            end
            if (accept) begin
                trig_num <= next_num;
            end else if (rst_trigger_num) begin
                trig_num <= '0;
            end
            case (ttr_state)
                TTR_IDLE: begin
                    if (accept) begin
                        ttr_state <= TTR_BUSY;
                    end
                end
                TTR_BUSY: begin
                    // acq_ready is still high while our pulse is out
                    if (acq_ready && !acq_trigger) begin
                        ttr_state <= TTR_IDLE;
                    end
                end
                default: ttr_state <= TTR_IDLE;
            endcase
        end
    end

    // record for the processor
    always_ff @(posedge ttc_clk) begin
        if (accept) begin
            acq_trig_num   <= next_num;
            acq_trig_type  <= trig_type;
            trig_timestamp <= ts_cnt;
            trig_rec       <= {ts_cnt, next_num, trig_type};
        end
    end

    a_trig_wr_pair: assert property (@(posedge ttc_clk) disable iff (!rst_n)
        acq_trigger == trig_wr)
        else $error("ttc_trigger_receiver: trigger and record write split");

endmodule

// File: rtl/event_fifo.sv
// Small synchronous FIFO

module event_fifo #(
    parameter int WIDTH = 32,
    parameter int DEPTH = 16            // power of two
) (
    input  logic             ttc_clk,
    input  logic             rst_n,
    input  logic             wr,        // write strobe
    input  logic [WIDTH-1:0] wdata,
    output logic             full,
    input  logic             rd,        // read strobe, pops the head
    output logic [WIDTH-1:0] rdata,     // first word falls through
    output logic             empty
);
    localparam int AW = $clog2(DEPTH);

    logic [WIDTH-1:0] mem [DEPTH];
    logic [AW:0]      wr_ptr;           // spare msb tells full from empty
    logic [AW:0]      rd_ptr;

    if ((1 << AW) != DEPTH) begin : g_depth_check
        $error("event_fifo: DEPTH must be a power of two");
    end

    assign empty = (wr_ptr == rd_ptr);
    assign full  = (wr_ptr == {~rd_ptr[AW], rd_ptr[AW-1:0]});   // one lap ahead
    assign rdata = mem[rd_ptr[AW-1:0]];

    // storage
    always_ff @(posedge ttc_clk) begin
        if (wr && !full) begin
            mem[wr_ptr[AW-1:0]] <= wdata;
        end
    end

    // pointers
    always_ff @(posedge ttc_clk) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (wr && !full) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (rd && !empty) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    // ----------------------------------------
    // the writer and reader keep to the flags
    // ----------------------------------------
    a_no_wr_full: assert property (@(posedge ttc_clk) disable iff (!rst_n) !(wr && full))
        else $error("event_fifo: write while full");

    a_no_rd_empty: assert property (@(posedge ttc_clk) disable iff (!rst_n) !(rd && empty))
        else $error("event_fifo: read while empty");

endmodule

// File: rtl/trigger_pkg.sv
// TTC trigger path definitions

package trigger_pkg;

    // ----------------------------------------
    // widths
    // ----------------------------------------
    localparam int NUM_CHAN = 5;                  // digitizer channels

    typedef logic [23:0]         trig_num_t;      // global trigger number, first is 1
    typedef logic [43:0]         timestamp_t;     // ttc_clk cycles
    typedef logic [ 4:0]         trig_type_t;     // muon fill, laser, pedestal ...
    typedef logic [NUM_CHAN-1:0] chan_mask_t;     // one bit per channel
    typedef logic [ 7:0]         delay_t;         // trigger delay in cycles

    // trigger record is {timestamp, number, type}, msb first
    localparam int TRIG_REC_W = $bits(timestamp_t) + $bits(trig_num_t) + $bits(trig_type_t);
    // acquisition record is {number, type}
    localparam int ACQ_REC_W  = $bits(trig_num_t) + $bits(trig_type_t);

    localparam int TRIG_FIFO_DEPTH = 16;
    localparam int ACQ_FIFO_DEPTH  = 16;

    // ----------------------------------------
    // state machines
    // ----------------------------------------
    typedef enum logic [0:0] {
        TTR_IDLE,
        TTR_BUSY        // trigger out, waiting for controller
    } ttr_state_t;

    typedef enum logic [1:0] {
        CAC_IDLE,
        CAC_DELAY,      // counting trig_delay
        CAC_ACQ,        // waiting for channel dones
        CAC_STORE       // event into acq fifo
    } cac_state_t;

    typedef enum logic [1:0] {
        TP_IDLE,
        TP_CHECK,       // outcome pulse cycle
        TP_READOUT      // waiting for readout_done
    } tp_state_t;

endpackage
